// File: sources.f
icache_pkg.sv
ic_array_if.sv
ic_refill_if.sv
icache_ctrl.sv
icache_way_array.sv
icache_axi_rd.sv
icache_fetch_pipe.sv
icache_top.sv
icache_props.sv
tb_icache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f sources.f \
   -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_icache > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// File: tb_icache.sv
// Testbench for the two-way instruction cache with an AXI memory model and a reference model
`timescale 1ns/1ns

module tb_icache
   import icache_pkg::*;
();

   localparam int CLK_PERIOD = 4;
   localparam int N_RAND     = 300;
   localparam int N_BP       = 200;
   localparam int N_DIR      = 20;
   localparam int N_LINES    = 64;     // Versioned memory lines
   localparam int N_SLOTS    = (1 << P_SETS) * NUM_WAYS;
   // Short gaps cost up to about 40 cycles per request, long gaps about 90
   localparam int WD_CYCLES  = 400 + (N_RAND + N_DIR) * 40 + N_BP * 90;

   logic                clk;
   logic                i_rst;
   logic                i_ce;
   logic                i_inv;
   logic [ADDR_W-1:0]   i_addr;
   logic [ADDR_W-1:0]   i_inv_addr;
   logic                i_arready;
   logic                i_rvalid;
   logic                i_rlast;
   logic [FETCH_W-1:0]  i_rdata;
   logic                o_stall;
   logic                o_valid;
   logic [FETCH_W-1:0]  o_ins;
   logic                o_arvalid;
   logic [ADDR_W-1:0]   o_araddr;
   logic                o_rready;

   // Reference model of tags, line versions and the replacement pointer
   logic [TAG_W-1:0]    m_tag [0:N_SLOTS-1];
   logic                m_vld [0:N_SLOTS-1];
   int                  m_ver [0:N_SLOTS-1];
   int                  m_ptr;
   logic                m_s1_valid;
   logic [ADDR_W-1:0]   m_s1_addr;
   int                  ver [0:N_LINES-1];
   logic [ADDR_W-1:0]   ar_q [$];      // Line addresses of predicted misses
   bit                  miss_log [$];  // Refill seen on the bus per judged request
   int                  ar_cnt;        // AR handshakes seen by the memory model
   bit                  long_gaps;
   int                  chk_cnt;
   int                  err_cnt;
   int                  err_start;
   int                  boot_cycles;

   icache_top dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Fetch window contents for a given line version
   function automatic logic [FETCH_W-1:0] word_of(input logic [ADDR_W-1:0] addr, input int v);
      logic [ADDR_W-1:0] wa;
      wa = {addr[ADDR_W-1:P_FETCH_BYTES], {P_FETCH_BYTES{1'b0}}};
      return {8'(v), 8'h5a, wa[15:0], ~wa};
   endfunction

   function automatic int rand_gap();
      return long_gaps ? int'($urandom_range(0, 12)) : int'($urandom_range(0, 1));
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check(input logic ok, input string what);
      chk_cnt++;
      assert (ok) else
      begin
         err_cnt++;
         $display("[ERROR] %0t ns: %s", $time, what);
      end
   endtask

   // Advances the model by one accepted edge, the stage 1 request moves to stage 2
   task automatic model_accept(input logic [ADDR_W-1:0] addr, input logic inv,
                               input logic [ADDR_W-1:0] inv_addr,
                               output logic exp_valid, output logic [FETCH_W-1:0] exp_ins);
      int set;
      int iset;
      int hit_w;
      set       = int'(m_s1_addr[P_LINE +: P_SETS]);
      iset      = int'(inv_addr[P_LINE +: P_SETS]);
      hit_w     = -1;
      exp_valid = m_s1_valid;
      exp_ins   = '0;
      if (m_s1_valid)
      begin
         for (int w = 0; w < NUM_WAYS; w++)
         begin
            if (m_vld[set*NUM_WAYS+w] && m_tag[set*NUM_WAYS+w] == m_s1_addr[ADDR_W-1 -: TAG_W])
               hit_w = w;
         end
         exp_ins = (hit_w >= 0) ? word_of(m_s1_addr, m_ver[set*NUM_WAYS+hit_w]) :
                                  word_of(m_s1_addr, ver[m_s1_addr[P_LINE +: 6]]);
      end
      if (inv)
      begin
         for (int w = 0; w < NUM_WAYS; w++)
            m_vld[iset*NUM_WAYS+w] = 1'b0;
      end
      if (m_s1_valid && hit_w < 0)   // Refill lands after the invalidate
      begin
         m_tag[set*NUM_WAYS+m_ptr] = m_s1_addr[ADDR_W-1 -: TAG_W];
         m_vld[set*NUM_WAYS+m_ptr] = 1'b1;
         m_ver[set*NUM_WAYS+m_ptr] = ver[m_s1_addr[P_LINE +: 6]];
         m_ptr = (m_ptr + 1) % NUM_WAYS;
         ar_q.push_back({m_s1_addr[ADDR_W-1:P_LINE], {P_LINE{1'b0}}});
      end
      m_s1_valid = 1'b1;
      m_s1_addr  = addr;
   endtask

   // One request on an edge with i_ce, then a check of the window that reached stage 2
   task automatic fetch(input logic [ADDR_W-1:0] addr, input logic inv,
                        input logic [ADDR_W-1:0] inv_addr);
      logic               exp_valid;
      logic [FETCH_W-1:0] exp_ins;
      logic [ADDR_W-1:0]  s2_addr;
      int                 ar_seen;
      s2_addr    = m_s1_addr;
      ar_seen    = ar_cnt;
      i_ce       = 1'b1;
      i_addr     = addr;
      i_inv      = inv;
      i_inv_addr = inv_addr;
      wait_cycles(1);
      i_ce  = 1'b0;
      i_inv = 1'b0;
      model_accept(addr, inv, inv_addr, exp_valid, exp_ins);
      while (o_stall)
         wait_cycles(1);
      if (exp_valid)
         miss_log.push_back(ar_cnt != ar_seen);   // The DUT went to the bus for it
      check(o_valid == exp_valid, $sformatf("o_valid is %0b, expected %0b", o_valid, exp_valid));
      if (exp_valid)
         check(o_ins == exp_ins, $sformatf("o_ins for 0x%08h is 0x%016h, expected 0x%016h",
                                           s2_addr, o_ins, exp_ins));
      if ($urandom_range(0, 3) == 0)
         wait_cycles(1);      // Idle cycle between requests
   endtask

   task automatic random_fetches(input int n);
      repeat (n)
         fetch(ADDR_W'($urandom_range(0, N_LINES * 4 - 1)) << P_FETCH_BYTES, 1'b0, '0);
   endtask

   task automatic close_test(input string name);
      check(ar_q.size() == 0, "a predicted miss never showed up on the AR channel");
      $display("%-16s done, %0d errors", name, err_cnt - err_start);
      err_start = err_cnt;
   endtask

   // AXI slave with random AR and R gaps, memory words follow the line versions
   initial
   begin : axi_mem
      logic [ADDR_W-1:0] line;
      logic [ADDR_W-1:0] exp_line;
      logic              rdy;
      forever
      begin
         @(posedge clk);
         #1;
         if (o_arvalid)
         begin
            wait_cycles(rand_gap());
            i_arready = 1'b1;
            line      = o_araddr;
            wait_cycles(1);
            i_arready = 1'b0;
            ar_cnt++;
            if (ar_q.size() == 0)
               check(1'b0, $sformatf("AR for line 0x%08h without a predicted miss", line));
            else
            begin
               exp_line = ar_q.pop_front();
               check(line == exp_line, $sformatf("o_araddr is 0x%08h, expected 0x%08h",
                                                 line, exp_line));
            end
            for (int b = 0; b < BEATS_PER_LINE; b++)
            begin
               wait_cycles(rand_gap());
               i_rvalid = 1'b1;
               i_rdata  = word_of(line + ADDR_W'(b << P_FETCH_BYTES), ver[line[P_LINE +: 6]]);
               i_rlast  = (b == BEATS_PER_LINE - 1);
               do
               begin
                  rdy = o_rready;
                  wait_cycles(1);
               end
               while (!rdy);
               i_rvalid = 1'b0;
               i_rlast  = 1'b0;
            end
         end
      end
   end

   initial
   begin : watchdog
      #(WD_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      void'($urandom(57981));
      i_rst      = 1'b1;
      i_ce       = 1'b0;
      i_addr     = '0;
      i_inv      = 1'b0;
      i_inv_addr = '0;
      i_arready  = 1'b0;
      i_rvalid   = 1'b0;
      i_rlast    = 1'b0;
      i_rdata    = '0;
      long_gaps  = 1'b0;
      m_ptr      = 0;
      m_s1_valid = 1'b0;
      m_s1_addr  = '0;
      ar_cnt     = 0;
      chk_cnt    = 0;
      err_cnt    = 0;
      err_start  = 0;
      for (int i = 0; i < N_SLOTS; i++)
      begin
         m_vld[i] = 1'b0;
         m_tag[i] = '0;
         m_ver[i] = 0;
      end
      for (int i = 0; i < N_LINES; i++)
         ver[i] = 0;
      repeat (8) @(posedge clk);
      #1 i_rst = 1'b0;

      // Boot clears one set per cycle
      boot_cycles = 0;
      check(!o_valid, "o_valid high after reset");
      while (o_stall && boot_cycles < 100)
      begin
         check(!o_arvalid && !o_rready, "AXI request raised during boot");
         boot_cycles++;
         wait_cycles(1);
      end
      check(boot_cycles == 16, $sformatf("boot stall lasted %0d cycles, expected 16", boot_cycles));
      close_test("boot");

      random_fetches(N_RAND);
      close_test("random_fetch");

      // Three lines in set 3, the third evicts the first
      fetch(32'h0010_0060, 1'b0, '0);
      miss_log.delete();
      fetch(32'h0010_0268, 1'b0, '0);
      fetch(32'h0010_0470, 1'b0, '0);
      fetch(32'h0010_0268, 1'b0, '0);
      fetch(32'h0010_0470, 1'b0, '0);
      fetch(32'h0010_0060, 1'b0, '0);
      fetch(32'h0000_0100, 1'b0, '0);
      check(miss_log.size() == 6 && miss_log[0] && miss_log[1] && miss_log[2] &&
            !miss_log[3] && !miss_log[4] && miss_log[5], "round-robin eviction order is wrong");
      close_test("replacement");

      // New line version in memory, then an invalidate of the cached copy
      fetch(32'h0000_0048, 1'b0, '0);
      fetch(32'h0000_00a0, 1'b0, '0);
      ver[2]++;
      fetch(32'h0000_00a8, 1'b1, 32'h0000_0048);
      miss_log.delete();
      fetch(32'h0000_0048, 1'b0, '0);
      fetch(32'h0000_0180, 1'b0, '0);
      check(miss_log.size() == 2 && miss_log[1], "invalidated line was not refilled");
      close_test("invalidation");

      long_gaps = 1'b1;
      random_fetches(N_BP);
      close_test("back_pressure");

      $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: icache_props.sv
// Concurrent assertions on the cache controller and the AXI burst reader, attached with bind
`timescale 1ns/1ns

module icache_props
   import icache_pkg::*;
(
   input  logic               clk,
   input  logic               i_rst,
   input  ic_state_e          i_state,
   input  way_vec_t           i_tag_we,
   input  logic               i_start,
   input  logic               i_arvalid,
   input  logic [ADDR_W-1:0]  i_araddr,
   input  logic               i_arready,
   input  logic               i_rvalid,
   input  logic               i_rlast,
   input  logic               i_rready
);

   // AR request holds its address until accepted
   a_ar_hold: assert property (@(posedge clk) disable iff (i_rst)
      (i_arvalid && !i_arready) |=> (i_arvalid && $stable(i_araddr)))
      else $error("AR request dropped or address changed before ARREADY");

   // Read ready opens only on the cycle after a refill start
   a_rready_open: assert property (@(posedge clk) disable iff (i_rst)
      $rose(i_rready) |-> $past(i_start))
      else $error("RREADY raised without a refill start");

   a_rready_close: assert property (@(posedge clk) disable iff (i_rst)
      (i_rready && i_rvalid && i_rlast) |=> !i_rready)
      else $error("RREADY still high after the last refill beat");

   // Exactly one way takes the new tag
   a_tag_we: assert property (@(posedge clk) disable iff (i_rst)
      (i_state == S_REPLACE) |-> $onehot(i_tag_we))
      else $error("tag write enables not one-hot during replace");

endmodule

bind icache_ctrl icache_props u_ctrl_props (
   .clk         (clk),
   .i_rst       (i_rst),
   .i_state     (state),
   .i_tag_we    (arr.tag_we),
   .i_start     (rf.start),
   .i_arvalid   (1'b0),
   .i_araddr    ('0),
   .i_arready   (1'b0),
   .i_rvalid    (rf.beat),
   .i_rlast     (rf.beat_last),
   .i_rready    (o_refilling)
);

bind icache_axi_rd icache_props u_bus_props (
   .clk         (clk),
   .i_rst       (i_rst),
   .i_state     (S_IDLE),
   .i_tag_we    ('0),
   .i_start     (rf.start),
   .i_arvalid   (o_arvalid),
   .i_araddr    (o_araddr),
   .i_arready   (i_arready),
   .i_rvalid    (i_rvalid),
   .i_rlast     (i_rlast),
   .i_rready    (o_rready)
);

// File: icache_top.sv
// Two-way instruction cache top level with fetch ports and an AXI burst read master
`timescale 1ns/1ns

module icache_top
   import icache_pkg::*;
(
   input  logic               clk,
   input  logic               i_rst,
   // Fetch side
   input  logic               i_ce,
   input  logic [ADDR_W-1:0]  i_addr,
   input  logic               i_inv,
   input  logic [ADDR_W-1:0]  i_inv_addr,
   output logic               o_stall,
   output logic [FETCH_W-1:0] o_ins,
   output logic               o_valid,
   // AXI read
   input  logic               i_arready,
   output logic               o_arvalid,
   output logic [ADDR_W-1:0]  o_araddr,
   input  logic               i_rvalid,
   input  logic [FETCH_W-1:0] i_rdata,
   input  logic               i_rlast,
   output logic               o_rready
);

   logic                s1_valid;
   logic [ADDR_W-1:0]   s1_addr;
   logic [ADDR_W-1:0]   s2_addr;
   logic                refilling;

   ic_array_if  u_arr_if ();
   ic_refill_if u_rf_if ();

   icache_ctrl u_ctrl (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_ce         (i_ce),
      .i_addr       (i_addr),
      .i_inv        (i_inv),
      .i_inv_addr   (i_inv_addr),
      .i_s1_valid   (s1_valid),
      .i_s1_addr    (s1_addr),
      .i_s2_addr    (s2_addr),
      .o_stall      (o_stall),
      .o_refilling  (refilling),
      .arr          (u_arr_if.ctrl),
      .rf           (u_rf_if.ctrl)
   );

   icache_way_array u_way_array (
      .clk          (clk),
      .arr          (u_arr_if.array),
      .rf           (u_rf_if.pipe),
      .i_s1_addr    (s1_addr)
   );

   icache_axi_rd u_axi_rd (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_s2_addr    (s2_addr),
      .i_arready    (i_arready),
      .i_rvalid     (i_rvalid),
      .i_rdata      (i_rdata),
      .i_rlast      (i_rlast),
      .i_refilling  (refilling),
      .o_arvalid    (o_arvalid),
      .o_araddr     (o_araddr),
      .o_rready     (o_rready),
      .rf           (u_rf_if.bus)
   );

   icache_fetch_pipe u_fetch_pipe (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_ce         (i_ce),
      .i_addr       (i_addr),
      .i_refilling  (refilling),
      .i_hit_data   (u_arr_if.hit_data),
      .o_s1_valid   (s1_valid),
      .o_s1_addr    (s1_addr),
      .o_s2_addr    (s2_addr),
      .o_ins        (o_ins),
      .o_valid      (o_valid),
      .rf           (u_rf_if.pipe)
   );

endmodule

// File: icache_fetch_pipe.sv
// Fetch pipeline with stage address and valid registers and the instruction output register
`timescale 1ns/1ns

module icache_fetch_pipe
   import icache_pkg::*;
(
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_ce,
   input  logic [ADDR_W-1:0]  i_addr,
   input  logic               i_refilling,
   input  logic [FETCH_W-1:0] i_hit_data,
   output logic               o_s1_valid,
   output logic [ADDR_W-1:0]  o_s1_addr,
   output logic [ADDR_W-1:0]  o_s2_addr,
   output logic [FETCH_W-1:0] o_ins,
   output logic               o_valid,
   ic_refill_if.pipe          rf
);

   logic    refill_match;

   // Beat carrying the window that stage 2 asked for
   assign refill_match = i_refilling & rf.beat &
                         (rf.beat_idx == o_s2_addr[P_FETCH_BYTES +: BEAT_W]);

   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         o_s1_valid <= 1'b0;
         o_valid    <= 1'b0;
      end
      else if (i_ce)
      begin
         o_s1_valid <= 1'b1;
         o_valid    <= o_s1_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_ce)
      begin
         o_s1_addr <= i_addr;
         o_s2_addr <= o_s1_addr;
         o_ins     <= i_hit_data;
      end
      else if (refill_match)
         o_ins <= rf.beat_data;     // Bypass from the bus
   end

endmodule

// File: icache_axi_rd.sv
// AXI burst reader for line refills with AR register, R ready and beat counter
`timescale 1ns/1ns

module icache_axi_rd
   import icache_pkg::*;
(
   input  logic               clk,
   input  logic               i_rst,
   input  logic [ADDR_W-1:0]  i_s2_addr,
   input  logic               i_arready,
   input  logic               i_rvalid,
   input  logic [FETCH_W-1:0] i_rdata,
   input  logic               i_rlast,
   input  logic               i_refilling,
   output logic               o_arvalid,
   output logic [ADDR_W-1:0]  o_araddr,
   output logic               o_rready,
   ic_refill_if.bus           rf
);

   logic [BEAT_W-1:0]   beat_cnt;

   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         o_arvalid <= 1'b0;
         beat_cnt  <= '0;
      end
      else
      begin
         if (rf.start)
            o_arvalid <= 1'b1;
         else if (i_arready)
            o_arvalid <= 1'b0;   // Address accepted
         if (rf.start)
            beat_cnt <= '0;
         else if (rf.beat)
            beat_cnt <= beat_cnt + 1'b1;
      end
   end

   // Line-aligned address, held until the handshake
   always_ff @(posedge clk)
   begin
      if (rf.start)
         o_araddr <= {i_s2_addr[ADDR_W-1:P_LINE], {P_LINE{1'b0}}};
   end

   assign o_rready     = i_refilling;
   assign rf.beat      = i_rvalid & o_rready;
   assign rf.beat_last = rf.beat & i_rlast;
   assign rf.beat_idx  = beat_cnt;
   assign rf.beat_data = i_rdata;

endmodule

// File: icache_way_array.sv
// Tag and payload storage for both ways, with tag compare and hit way select
`timescale 1ns/1ns

module icache_way_array
   import icache_pkg::*;
(
   input  logic               clk,
   ic_array_if.array          arr,
   ic_refill_if.pipe          rf,
   input  logic [ADDR_W-1:0]  i_s1_addr
);

   logic [TAG_W-1:0]                   s1_tag;
   way_vec_t                           hit_vec;
   logic [NUM_WAYS-1:0][FETCH_W-1:0]   way_data;

   assign s1_tag = i_s1_addr[ADDR_W-1 -: TAG_W];

   for (genvar w = 0; w < NUM_WAYS; w++)
   begin : g_way
      logic [TAG_W:0]      tag_mem [0:(1<<P_SETS)-1];     // {tag, valid}
      logic [FETCH_W-1:0]  pay_mem [0:(1<<PAYLOAD_AW)-1];
      logic [TAG_W:0]      tag_q;
      logic [FETCH_W-1:0]  pay_q;

      always_ff @(posedge clk)
      begin
         if (arr.tag_we[w])
            tag_mem[arr.line_addr] <= arr.tag_wdata;
         if (arr.payload_we[w])
            pay_mem[arr.payload_addr] <= rf.beat_data;
         if (arr.rd_en)
         begin
            tag_q <= tag_mem[arr.line_addr];
            pay_q <= pay_mem[arr.payload_addr];
         end
      end

      assign hit_vec[w]  = tag_q[0] & (tag_q[TAG_W:1] == s1_tag);
      assign way_data[w] = pay_q;
   end

   assign arr.hit = |hit_vec;

   // At most one way matches, so an OR of the masked windows is enough
   always_comb
   begin
      arr.hit_data = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         arr.hit_data = arr.hit_data | (way_data[w] & {FETCH_W{hit_vec[w]}});
      end
   end

endmodule

// File: icache_ctrl.sv
// Cache controller with the miss FSM, boot counter, way pointer and array address muxes
`timescale 1ns/1ns

module icache_ctrl
   import icache_pkg::*;
(
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_ce,
   input  logic [ADDR_W-1:0]  i_addr,
   input  logic               i_inv,
   input  logic [ADDR_W-1:0]  i_inv_addr,
   input  logic               i_s1_valid,
   input  logic [ADDR_W-1:0]  i_s1_addr,
   input  logic [ADDR_W-1:0]  i_s2_addr,
   output logic               o_stall,
   output logic               o_refilling,
   ic_array_if.ctrl           arr,
   ic_refill_if.ctrl          rf
);

   ic_state_e           state;
   ic_state_e           state_nxt;
   logic [P_SETS-1:0]   boot_cnt;
   logic [P_SETS:0]     boot_nxt;      // Carry marks the last set
   logic [P_SETS-1:0]   inv_set;
   logic                pend_miss;
   way_vec_t            repl_ptr;
   way_vec_t            refill_way;
   logic                miss;

   // Stage 1 lookup result is judged when the request moves to stage 2
   assign miss = i_ce & i_s1_valid & ~arr.hit;

   assign boot_nxt = {1'b0, boot_cnt} + 1'b1;

   always_comb
   begin
      state_nxt = state;
      case (state)
         S_BOOT:       if (boot_nxt[P_SETS]) state_nxt = S_IDLE;
         S_IDLE:
         begin
            if (i_ce & i_inv)
               state_nxt = S_INVALIDATE;
            else if (miss)
               state_nxt = S_REPLACE;
         end
         // Stage 1 tags are stale once a set is cleared, so re-read them
         S_INVALIDATE: state_nxt = pend_miss ? S_REPLACE : S_RELOAD;
         S_REPLACE:    state_nxt = S_REFILL;
         S_REFILL:     if (rf.beat_last) state_nxt = S_RELOAD;
         S_RELOAD:     state_nxt = S_IDLE;
         default:      state_nxt = S_BOOT;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         state     <= S_BOOT;
         boot_cnt  <= '0;
         pend_miss <= 1'b0;
         repl_ptr  <= way_vec_t'(1);
      end
      else
      begin
         state <= state_nxt;
         if (state == S_BOOT)
            boot_cnt <= boot_nxt[P_SETS-1:0];
         if (state == S_IDLE && i_ce)
            pend_miss <= miss;    // Held across an invalidate
         if (state == S_REPLACE)
            repl_ptr <= {repl_ptr[NUM_WAYS-2:0], repl_ptr[NUM_WAYS-1]};
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_ce)
         inv_set <= i_inv_addr[P_LINE +: P_SETS];
      if (state == S_REPLACE)
         refill_way <= repl_ptr;  // Way that takes the refill beats
   end

   // Tag array set index
   always_comb
   begin
      case (state)
         S_BOOT:       arr.line_addr = boot_cnt;
         S_INVALIDATE: arr.line_addr = inv_set;
         S_REPLACE:    arr.line_addr = i_s2_addr[P_LINE +: P_SETS];
         S_RELOAD:     arr.line_addr = i_s1_addr[P_LINE +: P_SETS];
         default:      arr.line_addr = i_addr[P_LINE +: P_SETS];
      endcase
   end

   // Payload address, the beat index comes from the bus reader while refilling
   always_comb
   begin
      case (state)
         S_REFILL: arr.payload_addr = {i_s2_addr[P_LINE +: P_SETS], rf.beat_idx};
         S_RELOAD: arr.payload_addr = i_s1_addr[P_FETCH_BYTES +: PAYLOAD_AW];
         default:  arr.payload_addr = i_addr[P_FETCH_BYTES +: PAYLOAD_AW];
      endcase
   end

   assign arr.tag_wdata  = (state == S_REPLACE) ? {i_s2_addr[ADDR_W-1 -: TAG_W], 1'b1} : '0;
   assign arr.tag_we     = (state == S_BOOT || state == S_INVALIDATE) ? '1 :
                           (state == S_REPLACE) ? repl_ptr : '0;
   assign arr.payload_we = (state == S_REFILL && rf.beat) ? refill_way : '0;
   assign arr.rd_en      = i_ce | (state == S_RELOAD);

   assign rf.start    = (state == S_REPLACE);
   assign o_refilling = (state == S_REFILL);
   assign o_stall     = (state != S_IDLE);

endmodule

// File: ic_refill_if.sv
// Refill start and beat signals shared by the controller, bus reader and fetch pipe
`timescale 1ns/1ns

interface ic_refill_if
   import icache_pkg::*;
();

   logic                start;      // One-cycle pulse from the controller
   logic                beat;       // R channel handshake
   logic                beat_last;
   logic [BEAT_W-1:0]   beat_idx;   // Position of the current beat in the line
   logic [FETCH_W-1:0]  beat_data;

   modport ctrl (output start, input beat, beat_last, beat_idx);

   modport bus  (input start, output beat, beat_last, beat_idx, beat_data);

   modport pipe (input beat, beat_idx, beat_data);

endinterface

// File: ic_array_if.sv
// Array port between the cache controller and the way arrays
`timescale 1ns/1ns

interface ic_array_if
   import icache_pkg::*;
();

   logic [P_SETS-1:0]      line_addr;     // Tag array set index
   logic [PAYLOAD_AW-1:0]  payload_addr;  // {set, beat}
   logic                   rd_en;
   way_vec_t               tag_we;
   logic [TAG_W:0]         tag_wdata;     // {tag, valid}
   way_vec_t               payload_we;

   logic                   hit;
   logic [FETCH_W-1:0]     hit_data;      // Window of the hitting way

   modport ctrl (
      output line_addr, payload_addr, rd_en, tag_we, tag_wdata, payload_we,
      input  hit
   );

   modport array (
      input  line_addr, payload_addr, rd_en, tag_we, tag_wdata, payload_we,
      output hit, hit_data
   );

endinterface

// File: icache_pkg.sv
// Instruction cache package with the geometry, address field widths and controller states
package icache_pkg;

   localparam int ADDR_W         = 32;   // Physical address
   localparam int P_LINE         = 5;    // 32-byte line
   localparam int P_SETS         = 4;    // 16 sets
   localparam int NUM_WAYS       = 2;

   // Fetch window holds two 32-bit instructions, same width as the AXI data bus
   localparam int FETCH_W        = 64;
   localparam int P_FETCH_BYTES  = 3;

   localparam int BEATS_PER_LINE = 1 << (P_LINE - P_FETCH_BYTES);
   localparam int BEAT_W         = $clog2(BEATS_PER_LINE); // Beat index within a line

   localparam int TAG_W          = ADDR_W - P_SETS - P_LINE;
   localparam int PAYLOAD_AW     = P_SETS + BEAT_W;       // {set index, beat index}

   typedef enum logic [2:0] {
      S_BOOT,        // Clearing every set after reset
      S_IDLE,
      S_INVALIDATE,  // Clearing one set on request
      S_REPLACE,     // Tag write and AR request
      S_REFILL,      // Burst beats into the payload
      S_RELOAD       // Re-read of the stage 1 request
   } ic_state_e;

   // One-hot way vector
   typedef logic [NUM_WAYS-1:0] way_vec_t;

endpackage
